// File: flist.f
+incdir+include
design/rcc_rst_pkg.sv
design/rcc_pwr_pkg.sv
design/rcc_input_sync.sv
design/rcc_rst_seq.sv
design/rcc_clk_on_delay.sv
design/rcc_lp_req.sv
design/rcc_clk_en_gen.sv
design/rcc_sys_rst_clk_ctrl.sv
tb/tb_clk_gen.sv
tb/rcc_props.sv
tb/tb_rcc.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rcc
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SRCS := $(shell grep -v '^+' $(FLIST)) include/rcc_cfg.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean
all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@! grep -q "Test failed" $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_rcc.sv
`timescale 1ns/10ps

module tb_rcc;
  import rcc_rst_pkg::*;
  import rcc_pwr_pkg::*;

  // summed test lengths in cycles, plus slack
  localparam int TEST_CYCLES = 700;
  localparam int MARGIN      = 400;

  logic       clk, i_reset, i_arcg_on;
  rst_src_t   i_rst_src;
  wwdg_ctl_t  i_wwdg_ctl;
  pwr_stat_t  i_pwr_stat;
  cpu_mode_t  i_cpu_mode;
  busy_t      i_busy;
  alloc_t     i_alloc;
  lp_req_t    i_wkup;
  rst_state_t o_rst;
  lp_req_t    o_lp_req;
  clk_en_t    o_clk_en;
  int         err_cnt = 0;
  int         bad_tests = 0;
  int         test_no = 0;
  logic [31:0] seed = 32'he0b69ee8;

  tb_clk_gen u_clk (.o_clk(clk));

  rcc_sys_rst_clk_ctrl rcc_sys_rst_clk_ctrl_i (.i_clk(clk), .*);

  bind rcc_sys_rst_clk_ctrl rcc_props u_props (
    .i_clk, .i_reset, .i_rst_src, .i_wwdg_ctl, .i_sync_stat(sync_stat), .i_cpu_mode,
    .i_busy, .i_alloc, .i_wkup, .i_arcg_on, .i_arcg_en(arcg_en), .o_rst, .o_lp_req,
    .o_clk_en);

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // 0 cpu resets released, 1 d1 request, 2 d3 request, 3 cpu1 clock, 4 sys reset released
  function automatic logic cond_met(input int sel);
    case (sel)
      0:       return o_rst.cpu1_rst_n & o_rst.cpu2_rst_n;
      1:       return o_lp_req.d1;
      2:       return o_lp_req.d3;
      3:       return o_clk_en.c1;
      default: return o_rst.sys_rst_n;
    endcase
  endfunction

  task automatic wait_until(input int sel, input int limit, input string what);
    for (int i = 0; i < limit; i++) begin
      @(negedge clk);
      if (cond_met(sel)) return;
    end
    $display("timed out after %0d cycles waiting for %s", limit, what);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_no++;
    if (err_cnt != errs_before) bad_tests++;
    $display("[%0t] test %0d %s: %s", $time, test_no, name,
             (err_cnt == errs_before) ? "ok" : "checks failed");
  endtask

  task automatic pulse_wwdg1(input logic scope);
    @(negedge clk);
    i_wwdg_ctl.ww1rsc = scope;
    @(negedge clk);
    i_rst_src.wwdg1 = 1'b1;
    @(negedge clk);
    i_rst_src.wwdg1 = 1'b0;
  endtask

  initial begin
    #(20ns * (TEST_CYCLES + MARGIN));
    $display("watchdog expired, the run did not finish in time");
    $display("Test failed");
    $finish;
  end

  initial begin
    int e;
    logic [31:0] r;
    i_reset    = 1'b1;
    i_arcg_on  = 1'b1;
    i_rst_src  = '0;
    i_wwdg_ctl = '0;
    // all supplies good, option bytes loaded
    i_pwr_stat = '{vcore_ok: 1, d1_ok: 1, d2_ok: 1, flash_power_ok: 1, hsi_rdy: 1,
                   obl_done: 1, obl_reload: 0};
    i_cpu_mode = '0;
    i_busy     = '0;
    i_alloc    = '0;
    i_wkup     = '0;

    e = err_cnt;
    repeat (16) @(negedge clk);
    i_reset = 1'b0;
    finish_test("reset", e);

    // boot, then a system wide wwdg1 reset
    e = err_cnt;
    wait_until(0, 60, "reset release after boot");
    wait_until(3, 20, "cpu1 clock after boot");
    pulse_wwdg1(1'b1);
    // flash supply lost just as the d1 count completes
    wait_until(4, 20, "sys reset release after wwdg1");
    repeat (8) @(negedge clk);
    i_pwr_stat.flash_power_ok = 1'b0;
    repeat (4) @(negedge clk);
    i_pwr_stat.flash_power_ok = 1'b1;
    wait_until(0, 60, "reset release after flash loss");
    wait_until(3, 20, "cpu1 clock after flash loss");
    finish_test("reset_seq", e);

    // local wwdg1 with clock-on delay bypassed
    e = err_cnt;
    i_arcg_on = 1'b0;
    pulse_wwdg1(1'b0);
    wait_until(0, 20, "cpu1 reset release");
    repeat (4) @(negedge clk);
    i_arcg_on = 1'b1;
    wait_until(3, 20, "cpu1 clock with arcg");
    finish_test("clk_on_delay", e);

    // d1 stop and wakeup, then d3 blocked by busy
    e = err_cnt;
    i_cpu_mode.c1_deepsleep = 1'b1;
    wait_until(1, 10, "d1 stop request");
    i_wkup.d1 = 1'b1;
    repeat (2) @(negedge clk);
    i_wkup.d1 = 1'b0;
    i_cpu_mode = '{c1_sleep: 0, c1_deepsleep: 1, c2_sleep: 0, c2_deepsleep: 1,
                   d3_deepsleep: 1};
    i_busy.apb4 = 1'b1;
    repeat (5) @(negedge clk);
    i_busy.apb4 = 1'b0;
    wait_until(2, 10, "d3 stop request");
    i_wkup = '1;
    repeat (2) @(negedge clk);
    i_cpu_mode = '0;
    i_wkup = '0;
    finish_test("stop_req", e);

    // random modes, allocation, busy and wakeups
    e = err_cnt;
    for (int i = 0; i < 300; i++) begin
      @(negedge clk);
      r = lcg_next();
      i_cpu_mode = cpu_mode_t'(r[4:0]);
      i_busy     = busy_t'(r[14:5] & r[24:15]);
      i_wkup     = lp_req_t'(r[27:25] & r[30:28]);
      r = lcg_next();
      i_alloc    = alloc_t'(r[13:0]);
    end
    finish_test("random_en", e);

    $display("tests: %0d, failing tests: %0d, failed checks: %0d",
             test_no, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tb/rcc_props.sv
`timescale 1ns/10ps
`include "rcc_cfg.svh"

module rcc_props (
  input logic                    i_clk,
  input logic                    i_reset,
  input rcc_rst_pkg::rst_src_t   i_rst_src,
  input rcc_rst_pkg::wwdg_ctl_t  i_wwdg_ctl,
  input rcc_rst_pkg::pwr_stat_t  i_sync_stat,
  input rcc_pwr_pkg::cpu_mode_t  i_cpu_mode,
  input rcc_pwr_pkg::busy_t      i_busy,
  input rcc_pwr_pkg::alloc_t     i_alloc,
  input rcc_pwr_pkg::lp_req_t    i_wkup,
  input logic                    i_arcg_on,
  input rcc_pwr_pkg::arcg_en_t   i_arcg_en,
  input rcc_rst_pkg::rst_state_t o_rst,
  input rcc_pwr_pkg::lp_req_t    o_lp_req,
  input rcc_pwr_pkg::clk_en_t    o_clk_en
);
  import rcc_rst_pkg::*;
  import rcc_pwr_pkg::*;

  cpu_mode_t m;
  clk_en_t   exp_en;
  logic      s1, s2, d1_idle, d3_idle, d1_bsy;

  assign m = i_cpu_mode;
  // light sleepers keep their allocated bridges running
  assign s1 = m.c1_sleep & ~m.c1_deepsleep;
  assign s2 = m.c2_sleep & ~m.c2_deepsleep;
  assign d1_bsy = i_busy.axi | i_busy.ahb3 | i_busy.apb3 | i_busy.flash;
  assign d1_idle = m.c1_deepsleep & ~d1_bsy & (m.c2_deepsleep | ~i_alloc.c2_per_alloc_d1);
  assign d3_idle = m.c1_deepsleep & m.c2_deepsleep & m.d3_deepsleep & (i_busy == '0);

  // reference enables built from the rules
  always_comb begin
    exp_en.c1     = ~(m.c1_sleep | m.c1_deepsleep) & i_arcg_en.cpu1;
    exp_en.c2     = ~(m.c2_sleep | m.c2_deepsleep) & i_arcg_en.cpu2;
    exp_en.sys    = ~o_lp_req.d3 & i_arcg_en.sys;
    exp_en.d1_bus = ~o_lp_req.d1 & i_arcg_en.d1;
    exp_en.d2_bus = ~o_lp_req.d2 & i_arcg_en.d2;
    exp_en.d3_bus = exp_en.sys;
    // d1 side, c1 owns it
    exp_en.axi  = exp_en.d1_bus & (~m.c1_sleep | i_busy.axi);
    exp_en.apb3 = exp_en.d1_bus & (~m.c1_sleep | (s1 & i_alloc.c1_apb3) |
                  (s2 & i_alloc.c2_apb3) | i_busy.apb3);
    exp_en.ahb3 = exp_en.d1_bus & (exp_en.apb3 | i_busy.flash | ~m.c1_sleep |
                  (s1 & i_alloc.c1_ahb3) | (s2 & i_alloc.c2_ahb3) | i_busy.ahb3);
    // d2 side, c2 owns it
    exp_en.apb1 = exp_en.d2_bus & (~m.c2_sleep | (s1 & i_alloc.c1_apb1) |
                  (s2 & i_alloc.c2_apb1) | i_busy.apb1);
    exp_en.apb2 = exp_en.d2_bus & (~m.c2_sleep | (s1 & i_alloc.c1_apb2) |
                  (s2 & i_alloc.c2_apb2) | i_busy.apb2);
    exp_en.ahb2 = exp_en.d2_bus & (~m.c2_sleep | (s1 & i_alloc.c1_ahb2) |
                  (s2 & i_alloc.c2_ahb2) | i_busy.ahb2);
    exp_en.ahb1 = exp_en.d2_bus & (exp_en.apb1 | exp_en.apb2 | ~m.c2_sleep |
                  (s1 & i_alloc.c1_ahb1) | (s2 & i_alloc.c2_ahb1) | i_busy.ahb1);
    exp_en.ahb4 = exp_en.d3_bus & ~o_lp_req.d3;
    exp_en.apb4 = exp_en.ahb4;
  end

  // ===================================================================
  // reset and sequencing
  // ===================================================================
  a_reset_zero: assert property (@(posedge i_clk) $past(i_reset) |->
      (o_rst == '0 && o_lp_req == '0 && o_clk_en == '0))
    else begin
      $error("[ERROR] %0t: outputs not cleared by reset", $time);
      tb_rcc.err_cnt++;
    end

  a_d1_len: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(o_rst.d1_rst_n) |-> $past(o_rst.sys_rst_n, `RCC_D1_RST_CYCLES) &&
      $past(i_sync_stat.flash_power_ok))
    else begin
      $error("[ERROR] %0t: d1 reset released too early", $time);
      tb_rcc.err_cnt++;
    end

  a_wwdg_sys: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(i_rst_src.wwdg1) && i_wwdg_ctl.ww1rsc && o_rst.sys_rst_n |->
      ##2 !o_rst.sys_rst_n)
    else begin
      $error("[ERROR] %0t: system wide wwdg1 did not drop sys reset", $time);
      tb_rcc.err_cnt++;
    end

  a_wwdg_cpu: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(i_rst_src.wwdg1) && !i_wwdg_ctl.ww1rsc && o_rst.sys_rst_n |->
      ##1 !o_rst.cpu1_rst_n ##1 o_rst.sys_rst_n)
    else begin
      $error("[ERROR] %0t: local wwdg1 reset scope wrong", $time);
      tb_rcc.err_cnt++;
    end

  // ===================================================================
  // clock-on delay, stop requests, enables
  // ===================================================================
  a_arcg_delay: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(o_rst.cpu1_rst_n) && i_arcg_on && m == '0 |->
      ##(`RCC_CLK_ON_DELAY) (o_clk_en.c1 && !$past(o_clk_en.c1)))
    else begin
      $error("[ERROR] %0t: cpu1 clock-on delay wrong", $time);
      tb_rcc.err_cnt++;
    end

  a_arcg_off: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(o_rst.cpu1_rst_n) && !i_arcg_on && m == '0 |-> o_clk_en.c1)
    else begin
      $error("[ERROR] %0t: cpu1 clock late without arcg", $time);
      tb_rcc.err_cnt++;
    end

  a_d1_set: assert property (@(posedge i_clk) disable iff (i_reset)
      d1_idle && !i_wkup.d1 && o_rst.sys_rst_n |=> o_lp_req.d1)
    else begin
      $error("[ERROR] %0t: d1 stop request missing", $time);
      tb_rcc.err_cnt++;
    end

  a_wkup: assert property (@(posedge i_clk) disable iff (i_reset)
      i_wkup != '0 |=> (o_lp_req & $past(i_wkup)) == '0)
    else begin
      $error("[ERROR] %0t: stop request survived its wakeup", $time);
      tb_rcc.err_cnt++;
    end

  a_d3: assert property (@(posedge i_clk) disable iff (i_reset)
      $rose(o_lp_req.d3) |-> $past(d3_idle))
    else begin
      $error("[ERROR] %0t: d3 request without full deepsleep", $time);
      tb_rcc.err_cnt++;
    end

  a_clk_en: assert property (@(posedge i_clk) disable iff (i_reset) o_clk_en == exp_en)
    else begin
      $error("[ERROR] %0t: clk_en %h expected %h", $time, o_clk_en, exp_en);
      tb_rcc.err_cnt++;
    end

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 20.0
) (
  output logic o_clk
);
  // free running, starts low
  initial o_clk = 1'b0;
  always #(PERIOD_NS / 2.0) o_clk = ~o_clk;

endmodule

// File: design/rcc_sys_rst_clk_ctrl.sv
`timescale 1ns/10ps

module rcc_sys_rst_clk_ctrl (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  rcc_rst_pkg::rst_src_t   i_rst_src,
  input  rcc_rst_pkg::wwdg_ctl_t  i_wwdg_ctl,
  input  rcc_rst_pkg::pwr_stat_t  i_pwr_stat,
  input  rcc_pwr_pkg::cpu_mode_t  i_cpu_mode,
  input  rcc_pwr_pkg::busy_t      i_busy,
  input  rcc_pwr_pkg::alloc_t     i_alloc,
  input  rcc_pwr_pkg::lp_req_t    i_wkup,
  input  logic                    i_arcg_on,
  output rcc_rst_pkg::rst_state_t o_rst,
  output rcc_pwr_pkg::lp_req_t    o_lp_req,
  output rcc_pwr_pkg::clk_en_t    o_clk_en
);
  import rcc_rst_pkg::*;
  import rcc_pwr_pkg::*;

  pwr_stat_t  sync_stat;
  rst_state_t rst;
  arcg_en_t   arcg_en;
  lp_req_t    lp_req;

  // status into the clock domain
  rcc_input_sync u_input_sync (.i_clk, .i_reset, .i_stat(i_pwr_stat), .o_stat(sync_stat));

  // resets, then clock-on delay, then enables
  rcc_rst_seq u_rst_seq (.i_clk, .i_reset, .i_rst_src, .i_wwdg_ctl,
                         .i_stat(sync_stat), .o_rst(rst));
  rcc_clk_on_delay u_clk_on_delay (.i_clk, .i_reset, .i_rst(rst), .i_arcg_on,
                                   .o_arcg_en(arcg_en));

  // stop requests to the power controller
  rcc_lp_req u_lp_req (.i_clk, .i_reset, .i_cpu_mode, .i_busy, .i_alloc, .i_wkup,
                       .i_sys_rst_n(rst.sys_rst_n), .o_lp_req(lp_req));

  rcc_clk_en_gen u_clk_en_gen (.i_cpu_mode, .i_busy, .i_alloc, .i_lp_req(lp_req),
                               .i_arcg_en(arcg_en), .o_clk_en);

  assign o_rst    = rst;
  assign o_lp_req = lp_req;

endmodule

// File: design/rcc_clk_en_gen.sv
`timescale 1ns/10ps

module rcc_clk_en_gen (
  input  rcc_pwr_pkg::cpu_mode_t i_cpu_mode,
  input  rcc_pwr_pkg::busy_t     i_busy,
  input  rcc_pwr_pkg::alloc_t    i_alloc,
  input  rcc_pwr_pkg::lp_req_t   i_lp_req,
  input  rcc_pwr_pkg::arcg_en_t  i_arcg_en,
  output rcc_pwr_pkg::clk_en_t   o_clk_en
);
  import rcc_pwr_pkg::*;

  logic    c1_lt, c2_lt;
  clk_en_t en;

  // plain sleep, not deepsleep
  assign c1_lt = i_cpu_mode.c1_sleep && !i_cpu_mode.c1_deepsleep;
  assign c2_lt = i_cpu_mode.c2_sleep && !i_cpu_mode.c2_deepsleep;

  // owner awake, or a lightly sleeping cpu owns it, or still busy
  function automatic logic bridge_on(input logic owner_sleep, input logic c1_a,
                                     input logic c2_a, input logic busy);
    return !owner_sleep || (c1_lt && c1_a) || (c2_lt && c2_a) || busy;
  endfunction

  always_comb begin
    // ===================================================================
    // cpu, system and domain bus
    // ===================================================================
    en.c1     = !i_cpu_mode.c1_sleep && !i_cpu_mode.c1_deepsleep && i_arcg_en.cpu1;
    en.c2     = !i_cpu_mode.c2_sleep && !i_cpu_mode.c2_deepsleep && i_arcg_en.cpu2;
    en.sys    = !i_lp_req.d3 && i_arcg_en.sys;
    // bus runs while its domain is not stopped
    en.d1_bus = !i_lp_req.d1 && i_arcg_en.d1;
    en.d2_bus = !i_lp_req.d2 && i_arcg_en.d2;
    en.d3_bus = en.sys;
    // ===================================================================
    // bridges, each under its domain bus
    // ===================================================================
    // axi is c1 only
    en.axi  = en.d1_bus && (!i_cpu_mode.c1_sleep || i_busy.axi);
    en.apb3 = en.d1_bus &&
              bridge_on(i_cpu_mode.c1_sleep, i_alloc.c1_apb3, i_alloc.c2_apb3, i_busy.apb3);
    // ahb3 feeds apb3 and the flash
    en.ahb3 = en.d1_bus && (en.apb3 || i_busy.flash ||
              bridge_on(i_cpu_mode.c1_sleep, i_alloc.c1_ahb3, i_alloc.c2_ahb3, i_busy.ahb3));
    en.apb1 = en.d2_bus &&
              bridge_on(i_cpu_mode.c2_sleep, i_alloc.c1_apb1, i_alloc.c2_apb1, i_busy.apb1);
    en.apb2 = en.d2_bus &&
              bridge_on(i_cpu_mode.c2_sleep, i_alloc.c1_apb2, i_alloc.c2_apb2, i_busy.apb2);
    en.ahb2 = en.d2_bus &&
              bridge_on(i_cpu_mode.c2_sleep, i_alloc.c1_ahb2, i_alloc.c2_ahb2, i_busy.ahb2);
    // apb1 and apb2 hang off ahb1
    en.ahb1 = en.d2_bus && (en.apb1 || en.apb2 ||
              bridge_on(i_cpu_mode.c2_sleep, i_alloc.c1_ahb1, i_alloc.c2_ahb1, i_busy.ahb1));
    // d3 bridges stop only with the d3 request
    en.ahb4 = en.d3_bus;
    en.apb4 = en.d3_bus;
  end

  assign o_clk_en = en;

endmodule

// File: design/rcc_lp_req.sv
`timescale 1ns/10ps

module rcc_lp_req (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  rcc_pwr_pkg::cpu_mode_t i_cpu_mode,
  input  rcc_pwr_pkg::busy_t     i_busy,
  input  rcc_pwr_pkg::alloc_t    i_alloc,
  input  rcc_pwr_pkg::lp_req_t   i_wkup,
  input  logic                   i_sys_rst_n,
  output rcc_pwr_pkg::lp_req_t   o_lp_req
);
  import rcc_pwr_pkg::*;

  logic    d1_busy, d2_busy, d3_busy;
  lp_req_t idle;
  lp_req_t req_q;

  // per domain busy, flash lives in d1
  assign d1_busy = i_busy.axi | i_busy.ahb3 | i_busy.apb3 | i_busy.flash;
  assign d2_busy = i_busy.ahb1 | i_busy.ahb2 | i_busy.apb1 | i_busy.apb2;
  // d3 waits for everything below it
  assign d3_busy = d1_busy | d2_busy | i_busy.ahb4 | i_busy.apb4;

  always_comb begin
    // owner stopped, other cpu stopped or holds nothing here, not busy
    idle.d1 = i_cpu_mode.c1_deepsleep && !d1_busy &&
              (i_cpu_mode.c2_deepsleep || !i_alloc.c2_per_alloc_d1);
    idle.d2 = i_cpu_mode.c2_deepsleep && !d2_busy &&
              (i_cpu_mode.c1_deepsleep || !i_alloc.c1_per_alloc_d2);
    idle.d3 = i_cpu_mode.c1_deepsleep && i_cpu_mode.c2_deepsleep &&
              i_cpu_mode.d3_deepsleep && !d3_busy;
  end

  // set on idle, wakeup wins and holds it clear
  always_ff @(posedge i_clk) begin
    if (i_reset || !i_sys_rst_n) req_q <= '0;
    else req_q <= lp_req_t'(~i_wkup & (req_q | idle));
  end

  assign o_lp_req = req_q;

endmodule

// File: design/rcc_clk_on_delay.sv
`timescale 1ns/10ps
`include "rcc_cfg.svh"

module rcc_clk_on_delay (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  rcc_rst_pkg::rst_state_t i_rst,
  input  logic                    i_arcg_on,
  output rcc_pwr_pkg::arcg_en_t   o_arcg_en
);
  import rcc_pwr_pkg::*;

  localparam int CW = $clog2(`RCC_CLK_ON_DELAY + 1);
  // sys, d1, d2, cpu1, cpu2
  localparam int NG = 5;

  logic [NG-1:0] rst_n;
  logic [NG-1:0] done;
  logic [NG-1:0] en;
  logic [CW-1:0] cnt_q [NG];

  // same order as arcg_en_t
  assign rst_n = {i_rst.sys_rst_n, i_rst.d1_rst_n, i_rst.d2_rst_n,
                  i_rst.cpu1_rst_n, i_rst.cpu2_rst_n};

  // count up after release, park at the delay
  always_ff @(posedge i_clk) begin
    for (int i = 0; i < NG; i++) begin
      if (i_reset || !rst_n[i]) cnt_q[i] <= '0;
      else if (!done[i])        cnt_q[i] <= cnt_q[i] + CW'(1);
    end
  end

  always_comb begin
    for (int i = 0; i < NG; i++) begin
      done[i] = (cnt_q[i] == CW'(`RCC_CLK_ON_DELAY));
    end
  end

  // reset low kills the clock at once
  // without arcg the enable just follows the reset
  assign en        = i_arcg_on ? (rst_n & done) : rst_n;
  assign o_arcg_en = arcg_en_t'(en);

endmodule

// File: design/rcc_rst_seq.sv
`timescale 1ns/10ps
`include "rcc_cfg.svh"

module rcc_rst_seq (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  rcc_rst_pkg::rst_src_t   i_rst_src,
  input  rcc_rst_pkg::wwdg_ctl_t  i_wwdg_ctl,
  input  rcc_rst_pkg::pwr_stat_t  i_stat,
  output rcc_rst_pkg::rst_state_t o_rst
);
  import rcc_rst_pkg::*;

  localparam int D1W = $clog2(`RCC_D1_RST_CYCLES + 1);
  localparam int D2W = $clog2(`RCC_D2_RST_CYCLES + 1);

  rst_src_t       src_q;
  logic           sys_assert, sys_release, sys_rst_n_q;
  logic           d1_clr, d2_clr;
  logic [D1W-1:0] d1_cnt_q;
  logic [D2W-1:0] d2_cnt_q;
  logic           d1_rst_n_q, d2_rst_n_q;

  // ===================================================================
  // system reset
  // ===================================================================
  always_ff @(posedge i_clk) begin
    if (i_reset) src_q <= '0;
    else         src_q <= i_rst_src;
  end

  // wwdg only counts when its scope is system wide
  assign sys_assert = src_q.por | src_q.bor | src_q.lpwr1 | src_q.lpwr2 |
                      src_q.iwdg1 | src_q.iwdg2 | src_q.cpu1_soft | src_q.cpu2_soft |
                      (src_q.wwdg1 & i_wwdg_ctl.ww1rsc) | (src_q.wwdg2 & i_wwdg_ctl.ww2rsc) |
                      !i_stat.vcore_ok | !i_stat.obl_done | i_stat.obl_reload;
  // release needs hsi and flash supply up
  assign sys_release = i_stat.hsi_rdy & i_stat.flash_power_ok & !sys_assert;

  always_ff @(posedge i_clk) begin
    if (i_reset) sys_rst_n_q <= 1'b0;
    else         sys_rst_n_q <= sys_release;
  end

  // ===================================================================
  // d1 / d2 standby resets
  // ===================================================================
  assign d1_clr = !sys_rst_n_q | !i_stat.d1_ok;
  assign d2_clr = !sys_rst_n_q | !i_stat.d2_ok;

  always_ff @(posedge i_clk) begin
    if (i_reset || d1_clr) begin
      d1_cnt_q   <= '0;
      d1_rst_n_q <= 1'b0;
    end else begin
      if (d1_cnt_q != D1W'(`RCC_D1_RST_CYCLES)) d1_cnt_q <= d1_cnt_q + D1W'(1);
      // flash sits in d1, wait for its supply
      else if (i_stat.flash_power_ok) d1_rst_n_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset || d2_clr) begin
      d2_cnt_q   <= '0;
      d2_rst_n_q <= 1'b0;
    end else begin
      if (d2_cnt_q != D2W'(`RCC_D2_RST_CYCLES)) d2_cnt_q <= d2_cnt_q + D2W'(1);
      else d2_rst_n_q <= 1'b1;
    end
  end

  // cpu and bus resets, straight from flops
  always_comb begin
    o_rst.sys_rst_n    = sys_rst_n_q;
    o_rst.d1_rst_n     = d1_rst_n_q;
    o_rst.d2_rst_n     = d2_rst_n_q;
    o_rst.cpu1_rst_n   = sys_rst_n_q & d1_rst_n_q & !src_q.wwdg1;
    o_rst.cpu2_rst_n   = sys_rst_n_q & d2_rst_n_q & !src_q.wwdg2;
    o_rst.d1_bus_rst_n = sys_rst_n_q & d1_rst_n_q;
    o_rst.d2_bus_rst_n = sys_rst_n_q & d2_rst_n_q;
    o_rst.d3_bus_rst_n = sys_rst_n_q;
  end

endmodule

// File: design/rcc_input_sync.sv
`timescale 1ns/10ps
`include "rcc_cfg.svh"

module rcc_input_sync (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  rcc_rst_pkg::pwr_stat_t i_stat,
  output rcc_rst_pkg::pwr_stat_t o_stat
);
  import rcc_rst_pkg::*;

  // one word per stage, stage 0 samples the async levels
  pwr_stat_t sync_q [`RCC_SYNC_STAGES];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      // all status reads as not ready
      for (int i = 0; i < `RCC_SYNC_STAGES; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= i_stat;
      for (int i = 1; i < `RCC_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // last stage is the usable copy
  assign o_stat = sync_q[`RCC_SYNC_STAGES-1];

endmodule

// File: design/rcc_pwr_pkg.sv
package rcc_pwr_pkg;

  // cpu and d3 low power state
  typedef struct packed {
    logic c1_sleep, c1_deepsleep;
    logic c2_sleep, c2_deepsleep;
    logic d3_deepsleep;
  } cpu_mode_t;

  // bridge busy levels, d1 then d2 then d3, plus flash
  typedef struct packed {
    logic axi, ahb3, apb3;
    logic ahb1, ahb2, apb1, apb2;
    logic ahb4, apb4;
    logic flash;
  } busy_t;

  // peripheral allocation per cpu
  typedef struct packed {
    logic c1_ahb1, c1_ahb2, c1_ahb3, c1_apb1, c1_apb2, c1_apb3;
    logic c2_ahb1, c2_ahb2, c2_ahb3, c2_apb1, c2_apb2, c2_apb3;
    logic c2_per_alloc_d1, c1_per_alloc_d2;
  } alloc_t;

  // stop requests to the power controller, or their wakeups
  typedef struct packed {
    logic d1, d2, d3;
  } lp_req_t;

  // clock-on after reset release
  typedef struct packed {
    logic sys, d1, d2, cpu1, cpu2;
  } arcg_en_t;

  typedef struct packed {
    logic c1, c2, sys, d1_bus, d2_bus, d3_bus;
    logic axi, ahb3, apb3, ahb1, ahb2, apb1, apb2, ahb4, apb4;
  } clk_en_t;

endpackage

// File: design/rcc_rst_pkg.sv
package rcc_rst_pkg;

  // reset source levels, all active high
  typedef struct packed {
    logic por, bor;
    logic lpwr1, lpwr2;
    logic iwdg1, iwdg2;
    logic wwdg1, wwdg2;
    logic cpu1_soft, cpu2_soft;
  } rst_src_t;

  // watchdog reset scope, set means system wide
  typedef struct packed {
    logic ww1rsc, ww2rsc;
  } wwdg_ctl_t;

  // power and flash status, raw or synchronized
  typedef struct packed {
    logic vcore_ok, d1_ok, d2_ok;
    logic flash_power_ok, hsi_rdy;
    logic obl_done, obl_reload;
  } pwr_stat_t;

  // active low resets out of the sequencer
  typedef struct packed {
    logic sys_rst_n, d1_rst_n, d2_rst_n;
    logic cpu1_rst_n, cpu2_rst_n;
    logic d1_bus_rst_n, d2_bus_rst_n, d3_bus_rst_n;
  } rst_state_t;

endpackage

// File: include/rcc_cfg.svh
`ifndef RCC_CFG_SVH
`define RCC_CFG_SVH

// d1 standby reset length after power-good, in cycles
`define RCC_D1_RST_CYCLES 10
// d2 standby reset length
`define RCC_D2_RST_CYCLES 10
// cycles from a reset release to its clock enable
`define RCC_CLK_ON_DELAY  8
// depth of the power status synchronizer
`define RCC_SYNC_STAGES   2
`endif
